/* src/csr_iq_settings.svh */
`ifndef CSR_IQ_SETTINGS_SVH
`define CSR_IQ_SETTINGS_SVH

// Queue geometry, depth must stay a power of two
`define CSR_IQ_DEPTH 8
`define CSR_IQ_PTR_W 3

`define ROB_IDX_W 5 // Without the wrap bit
`define PREG_W    6
`define XLEN      64
`define VADDR_W   39
`define ASID_W    16

// Writes to these CSRs change translation or protection state
`define CSR_MSTATUS 12'h300
`define CSR_SSTATUS 12'h100
`define CSR_PMP_LO  12'h3a0
`define CSR_PMP_HI  12'h3ef

`endif

/* src/csr_iq_pkg.sv */
`default_nettype none

`include "csr_iq_settings.svh"

package csr_iq_pkg;

    typedef logic [`CSR_IQ_PTR_W-1:0] iq_ptr_t;
    typedef logic [`CSR_IQ_PTR_W:0]   iq_cnt_t; // Slot index plus wrap bit, also a length
    typedef logic [`ROB_IDX_W:0]      rob_idx_t; // MSB is the wrap bit
    typedef logic [`PREG_W-1:0]       preg_t;
    typedef logic [`XLEN-1:0]         xlen_t;
    typedef logic [11:0]              csr_addr_t;
    typedef logic [`VADDR_W-1:0]      vaddr_t;
    typedef logic [`ASID_W-1:0]       asid_t;

    typedef enum logic [2:0] {
        CSRRW,
        CSRRS,
        CSRRC,
        FENCE,
        FENCE_I,
        SFENCE_VMA
    } csr_op_t;

    typedef enum logic {
        IDLE,
        WRITING
    } iq_state_t;

    typedef struct packed {
        csr_op_t   op;
        csr_addr_t csr_addr;
        preg_t     rs1;
        preg_t     rs2;
        preg_t     rd;
        logic      we;
        rob_idx_t  rob_idx;
    } csr_entry_t;

    typedef struct packed {
        xlen_t rs1_data;
        xlen_t rs2_data;
    } operand_t;

    typedef struct packed {
        logic     req;
        rob_idx_t rob_idx;
    } fence_req_t;

    typedef struct packed {
        logic   all;
        vaddr_t vaddr;
        asid_t  asid;
    } mmu_flush_t;

endpackage

`default_nettype wire

/* src/csr_queue_ptrs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_iq_settings.svh"

module csr_queue_ptrs
    import csr_iq_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       dis_valid,
    input  wire       redirect,
    input  wire       release_en,
    input  wire       iq_cnt_t keep_count,
    output logic      enq,
    output iq_ptr_t   head,
    output iq_ptr_t   tail,
    output iq_cnt_t   count,
    output logic      empty,
    output logic      full
);

    iq_cnt_t head_w;
    iq_cnt_t tail_w;

    assign head  = head_w[`CSR_IQ_PTR_W-1:0];
    assign tail  = tail_w[`CSR_IQ_PTR_W-1:0];
    assign empty = (head_w == tail_w);
    assign full  = (head == tail) && (head_w[`CSR_IQ_PTR_W] != tail_w[`CSR_IQ_PTR_W]);
    assign count = tail_w - head_w; // Modular difference gives the occupied length

    // Dispatch is dropped while full or during a redirect
    assign enq = dis_valid && !full && !redirect;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_w <= '0;
            tail_w <= '0;
        end else begin
            if (release_en) begin
                head_w <= head_w + 1'b1;
            end
            // The carry into the top bit of the sum yields the new wrap bit
            if (redirect) begin
                tail_w <= head_w + keep_count;
            end else if (enq) begin
                tail_w <= tail_w + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/csr_queue_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_iq_settings.svh"

module csr_queue_store
    import csr_iq_pkg::*;
(
    input  wire             clk,
    input  wire             enq,
    input  wire iq_ptr_t    tail,
    input  wire csr_entry_t dis_entry,
    input  wire iq_ptr_t    head,
    input  wire iq_cnt_t    count,
    input  wire rob_idx_t   redirect_rob_idx,
    output csr_entry_t      head_entry,
    output iq_cnt_t         keep_count
);

    csr_entry_t entries [`CSR_IQ_DEPTH];

    logic    stop;
    iq_ptr_t slot;

    // True when a is strictly older than b in ROB order
    function automatic logic is_older(input rob_idx_t a, input rob_idx_t b);
        if (a[`ROB_IDX_W] == b[`ROB_IDX_W]) begin
            return a[`ROB_IDX_W-1:0] < b[`ROB_IDX_W-1:0];
        end
        return a[`ROB_IDX_W-1:0] > b[`ROB_IDX_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (enq) begin
            entries[tail] <= dis_entry;
        end
    end

    assign head_entry = entries[head];

    // Survivors form a run starting at the head, the first younger slot ends it
    always_comb begin
        keep_count = '0;
        stop       = 1'b0;
        slot       = head;
        for (int i = 0; i < `CSR_IQ_DEPTH; i++) begin
            slot = head + iq_ptr_t'(i);
            if (!stop && (i < count) && is_older(entries[slot].rob_idx, redirect_rob_idx)) begin
                keep_count = keep_count + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/csr_issue_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_fsm
    import csr_iq_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             empty,
    input  wire csr_entry_t head_entry,
    input  wire rob_idx_t   commit_rob_idx,
    input  wire             exec_ready,
    input  wire             redirect,
    input  wire iq_cnt_t    keep_count,
    output logic            issue_valid,
    output csr_entry_t      issue_entry,
    output logic            release_en
);

    iq_state_t state;
    logic      select;
    logic      kill;
    logic      issue_q;

    // A redirect that keeps nothing also removes the entry being worked on
    assign kill = redirect && (keep_count == '0);

    // Only the oldest uncommitted instruction may go, so nothing here is speculative
    assign select = !empty && (state == IDLE) && (head_entry.rob_idx == commit_rob_idx) &&
                    !redirect && exec_ready;

    // The commit pointer moving past our instruction means it has retired
    assign release_en  = (state == WRITING) && (commit_rob_idx != issue_entry.rob_idx) && !kill;
    assign issue_valid = issue_q && !kill;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            issue_q <= 1'b0;
        end else begin
            issue_q <= select;
            if (kill) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (select) begin
                            state <= WRITING;
                        end
                    end
                    WRITING: begin
                        if (release_en) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Holds the rob_idx that release compares against
    always_ff @(posedge clk) begin
        if (select) begin
            issue_entry <= head_entry;
        end
    end

endmodule

`default_nettype wire

/* src/fence_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_iq_settings.svh"

module fence_sequencer
    import csr_iq_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             issue_valid,
    input  wire csr_entry_t issue_entry,
    input  wire operand_t   operands,
    input  wire             release_en,
    input  wire             redirect,
    input  wire iq_cnt_t    keep_count,
    input  wire             fence_commit,
    input  wire             store_flush_end,
    input  wire             inst_flush_end,
    input  wire             mmu_flush_end,
    output fence_req_t      fence_req,
    output logic            fence_valid,
    output logic            store_flush,
    output logic            inst_flush,
    output logic            mmu_flush,
    output mmu_flush_t      mmu_flush_info,
    output logic            fence_end
);

    csr_op_t  op_q;
    operand_t opnd_q;
    logic     fence_pend;
    logic     sfence_pend;
    logic     fencei_pend;
    logic     inst_done;
    logic     fencei_fire;
    logic     is_csr;
    logic     kill;

    function automatic logic needs_fence(input csr_entry_t e);
        if (e.op == FENCE || e.op == FENCE_I || e.op == SFENCE_VMA) begin
            return 1'b1;
        end
        return (e.csr_addr == `CSR_MSTATUS) || (e.csr_addr == `CSR_SSTATUS) ||
               ((e.csr_addr >= `CSR_PMP_LO) && (e.csr_addr <= `CSR_PMP_HI));
    endfunction

    assign is_csr = (op_q == CSRRW) || (op_q == CSRRS) || (op_q == CSRRC);
    assign kill   = redirect && (keep_count == '0);

    // FENCE.I may see its icache flush end before the store buffer drains
    assign fencei_fire = fencei_pend && (inst_done || inst_flush_end) && !store_flush;

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_q   <= issue_entry.op;
            opnd_q <= operands;
        end
        if (fence_commit && op_q == SFENCE_VMA) begin
            mmu_flush_info <= '{all:   (opnd_q.rs1_data[`VADDR_W-1:0] == '0),
                                vaddr: opnd_q.rs1_data[`VADDR_W-1:0],
                                asid:  opnd_q.rs2_data[`ASID_W-1:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fence_req <= '0;
        end else begin
            if (issue_valid) begin
                fence_req.req     <= needs_fence(issue_entry);
                fence_req.rob_idx <= issue_entry.rob_idx;
            end
            if (release_en || kill) begin
                fence_req.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fence_valid <= 1'b0;
            store_flush <= 1'b0;
            inst_flush  <= 1'b0;
            mmu_flush   <= 1'b0;
            fence_end   <= 1'b0;
            fence_pend  <= 1'b0;
            sfence_pend <= 1'b0;
            fencei_pend <= 1'b0;
            inst_done   <= 1'b0;
        end else begin
            if (fence_commit) begin
                fence_valid <= 1'b1;
                store_flush <= !is_csr;
                fence_pend  <= (op_q == FENCE);
                sfence_pend <= (op_q == SFENCE_VMA);
                fencei_pend <= (op_q == FENCE_I);
            end
            inst_flush <= fence_commit && (op_q == FENCE_I);
            mmu_flush  <= sfence_pend && store_flush_end;

            if (store_flush && store_flush_end) begin
                store_flush <= 1'b0;
            end
            if (store_flush_end) begin
                fence_pend  <= 1'b0;
                sfence_pend <= 1'b0;
            end
            if (fencei_pend && inst_flush_end) begin
                inst_done <= 1'b1;
            end
            if (fencei_fire) begin
                fencei_pend <= 1'b0;
                inst_done   <= 1'b0;
            end

            fence_end <= mmu_flush_end || (fence_commit && is_csr) ||
                         (fence_pend && store_flush_end) || fencei_fire;
            if (fence_end) begin
                fence_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/csr_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_top
    import csr_iq_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             dis_valid,
    input  wire csr_entry_t dis_entry,
    output logic            queue_full,
    input  wire rob_idx_t   commit_rob_idx,
    input  wire             fence_commit,
    input  wire             redirect,
    input  wire rob_idx_t   redirect_rob_idx,
    input  wire             exec_ready,
    output logic            issue_valid,
    output csr_entry_t      issue_entry,
    input  wire operand_t   operands,
    output fence_req_t      fence_req,
    output logic            fence_valid,
    output logic            store_flush,
    output logic            inst_flush,
    output logic            mmu_flush,
    output mmu_flush_t      mmu_flush_info,
    output logic            fence_end,
    input  wire             store_flush_end,
    input  wire             inst_flush_end,
    input  wire             mmu_flush_end
);

    logic       enq;
    logic       empty;
    logic       release_en;
    iq_ptr_t    head;
    iq_ptr_t    tail;
    iq_cnt_t    count;
    iq_cnt_t    keep_count;
    csr_entry_t head_entry;

    csr_queue_ptrs ptrs_i (
        .clk        (clk),
        .rst        (rst),
        .dis_valid  (dis_valid),
        .redirect   (redirect),
        .release_en (release_en),
        .keep_count (keep_count),
        .enq        (enq),
        .head       (head),
        .tail       (tail),
        .count      (count),
        .empty      (empty),
        .full       (queue_full)
    );

    csr_queue_store store_i (
        .clk              (clk),
        .enq              (enq),
        .tail             (tail),
        .dis_entry        (dis_entry),
        .head             (head),
        .count            (count),
        .redirect_rob_idx (redirect_rob_idx),
        .head_entry       (head_entry),
        .keep_count       (keep_count)
    );

    csr_issue_fsm fsm_i (
        .clk            (clk),
        .rst            (rst),
        .empty          (empty),
        .head_entry     (head_entry),
        .commit_rob_idx (commit_rob_idx),
        .exec_ready     (exec_ready),
        .redirect       (redirect),
        .keep_count     (keep_count),
        .issue_valid    (issue_valid),
        .issue_entry    (issue_entry),
        .release_en     (release_en)
    );

    fence_sequencer fence_i (
        .clk             (clk),
        .rst             (rst),
        .issue_valid     (issue_valid),
        .issue_entry     (issue_entry),
        .operands        (operands),
        .release_en      (release_en),
        .redirect        (redirect),
        .keep_count      (keep_count),
        .fence_commit    (fence_commit),
        .store_flush_end (store_flush_end),
        .inst_flush_end  (inst_flush_end),
        .mmu_flush_end   (mmu_flush_end),
        .fence_req       (fence_req),
        .fence_valid     (fence_valid),
        .store_flush     (store_flush),
        .inst_flush      (inst_flush),
        .mmu_flush       (mmu_flush),
        .mmu_flush_info  (mmu_flush_info),
        .fence_end       (fence_end)
    );

endmodule

`default_nettype wire

/* sim/csr_issue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_iq_settings.svh"

module csr_issue_tb
    import csr_iq_pkg::*;
();

    localparam int NUM_INSTR   = 200;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR + 200;

    logic       clk;
    logic       rst;
    logic       dis_valid;
    csr_entry_t dis_entry;
    logic       queue_full;
    rob_idx_t   commit_rob_idx;
    logic       fence_commit;
    logic       redirect;
    rob_idx_t   redirect_rob_idx;
    logic       exec_ready;
    logic       issue_valid;
    csr_entry_t issue_entry;
    operand_t   operands;
    fence_req_t fence_req;
    logic       fence_valid;
    logic       store_flush;
    logic       inst_flush;
    logic       mmu_flush;
    mmu_flush_t mmu_flush_info;
    logic       fence_end;
    logic       store_flush_end;
    logic       inst_flush_end;
    logic       mmu_flush_end;

    logic [31:0] lfsr = 32'hce20_0cbd;
    csr_entry_t  q[$]; // Queue model with the oldest uncommitted entry in q[0]
    rob_idx_t    next_rob;
    logic        head_issued;
    int          cdelay;
    operand_t    iss_opnd;
    csr_op_t     fop;
    mmu_flush_t  fence_info;
    fence_req_t  exp_req;
    logic        exp_valid;
    logic        exp_store;
    logic        exp_inst;
    logic        exp_mmu;
    logic        exp_end;
    logic        fi_pend;
    logic        fi_inst;
    int          st_cnt;
    int          in_cnt;
    int          mm_cnt;
    int          enq_total;
    int          cycles;
    logic        done;

    csr_issue_top csr_issue_top_i (.*);

    always #5 clk = ~clk;

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Fences and writes to status or PMP CSRs need the pipeline drained
    function automatic logic fence_needed(input csr_entry_t e);
        if (e.op == FENCE || e.op == FENCE_I || e.op == SFENCE_VMA) begin
            return 1'b1;
        end
        return (e.csr_addr == `CSR_MSTATUS) || (e.csr_addr == `CSR_SSTATUS) ||
               (e.csr_addr >= `CSR_PMP_LO && e.csr_addr <= `CSR_PMP_HI);
    endfunction

    function automatic csr_entry_t random_entry();
        csr_entry_t  e;
        logic [63:0] sel;
        sel        = take_bits(3) % 6;
        e.op       = csr_op_t'(sel[2:0]);
        sel        = take_bits(2);
        case (sel[1:0])
            2'd0:    e.csr_addr = `CSR_MSTATUS;
            2'd1:    e.csr_addr = `CSR_SSTATUS;
            2'd2:    e.csr_addr = `CSR_PMP_LO + csr_addr_t'(take_bits(6));
            default: e.csr_addr = csr_addr_t'(take_bits(12));
        endcase
        e.rs1      = preg_t'(take_bits(`PREG_W));
        e.rs2      = preg_t'(take_bits(`PREG_W));
        e.rd       = preg_t'(take_bits(`PREG_W));
        sel        = take_bits(1);
        e.we       = sel[0];
        e.rob_idx  = next_rob;
        return e;
    endfunction

    task automatic stop_on_error(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_entry(input string name, input csr_entry_t got, input csr_entry_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_fence_req(input string name, input fence_req_t got,
                                   input fence_req_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_mmu(input string name, input mmu_flush_t got, input mmu_flush_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Each falling edge checks what the last rising edge produced and drives the next cycle
    task automatic step();
        logic       sf_now;
        logic       fv_now;
        logic       do_commit;
        int         k;
        csr_entry_t e;
        csr_entry_t head;
        sf_now = store_flush;
        fv_now = fence_valid;
        check_bit("queue_full", queue_full, q.size() == `CSR_IQ_DEPTH);
        check_bit("fence_valid", fence_valid, exp_valid);
        check_bit("store_flush", store_flush, exp_store);
        check_bit("inst_flush", inst_flush, exp_inst);
        check_bit("mmu_flush", mmu_flush, exp_mmu);
        check_bit("fence_end", fence_end, exp_end);
        if (exp_req.req) begin
            check_fence_req("fence_req", fence_req, exp_req);
        end else begin
            check_bit("fence_req.req", fence_req.req, 1'b0);
        end
        if (mmu_flush) begin
            check_mmu("mmu_flush_info", mmu_flush_info, fence_info);
            mm_cnt = 1 + int'(take_bits(2));
        end
        if (issue_valid) begin
            if (q.size() == 0) stop_on_error("issue_valid rose with no entry queued");
            if (head_issued) stop_on_error("issue_valid rose again before the head committed");
            check_entry("issue_entry", issue_entry, q[0]);
            head_issued = 1'b1;
            cdelay      = 2 + int'(take_bits(2)); // Commit lands 1 to 4 cycles after the issue
            exp_req     = '{req: fence_needed(q[0]), rob_idx: q[0].rob_idx};
        end
        if (fence_end) exp_valid = 1'b0;
        exp_end = 1'b0;
        exp_mmu = 1'b0;
        exp_inst = 1'b0;

        fence_commit    = 1'b0;
        store_flush_end = 1'b0;
        inst_flush_end  = 1'b0;
        mmu_flush_end   = 1'b0;
        redirect        = 1'b0;
        dis_valid       = 1'b0;

        if (st_cnt > 0) begin
            st_cnt--;
            if (st_cnt == 0) begin
                store_flush_end = 1'b1;
                exp_store       = 1'b0;
                exp_end         = (fop == FENCE);
                exp_mmu         = (fop == SFENCE_VMA);
            end
        end
        if (mm_cnt > 0) begin
            mm_cnt--;
            if (mm_cnt == 0) begin
                mmu_flush_end = 1'b1;
                exp_end       = 1'b1;
            end
        end
        if (in_cnt > 0) begin
            in_cnt--;
            if (in_cnt == 0) begin
                inst_flush_end = 1'b1;
                fi_inst        = 1'b1;
            end
        end
        // FENCE.I ends once its icache flush is done and the store buffer has drained
        if (fi_pend && fi_inst && !sf_now) begin
            exp_end = 1'b1;
            fi_pend = 1'b0;
        end

        do_commit = 1'b0;
        if (head_issued) begin
            if (cdelay > 0) cdelay--;
            do_commit = (cdelay == 0) && !(fence_needed(q[0]) && fv_now);
        end
        if (do_commit) begin
            head        = q.pop_front();
            head_issued = 1'b0;
            exp_req.req = 1'b0;
            if (fence_needed(head)) begin
                fence_commit = 1'b1;
                fop          = head.op;
                exp_valid    = 1'b1;
                exp_store    = (fop == FENCE || fop == FENCE_I || fop == SFENCE_VMA);
                exp_inst     = (fop == FENCE_I);
                exp_end      = !exp_store;
                fi_pend      = (fop == FENCE_I);
                fi_inst      = 1'b0;
                if (exp_store) st_cnt = 1 + int'(take_bits(2));
                if (fop == FENCE_I) in_cnt = 1 + int'(take_bits(2));
                fence_info.vaddr = iss_opnd.rs1_data[`VADDR_W-1:0];
                fence_info.asid  = iss_opnd.rs2_data[`ASID_W-1:0];
                fence_info.all   = (fence_info.vaddr == '0);
            end
        end else if (q.size() >= 2 && take_bits(5) == 0) begin
            // The branch sits behind entry k-1, so the head always survives
            k                = 1 + int'(take_bits(3) % q.size());
            redirect         = 1'b1;
            redirect_rob_idx = (k == q.size()) ? next_rob : q[k].rob_idx;
            next_rob         = redirect_rob_idx;
            while (q.size() > k) begin
                void'(q.pop_back());
            end
        end

        if (enq_total < NUM_INSTR && take_bits(1)) begin
            e         = random_entry();
            dis_valid = 1'b1;
            dis_entry = e;
            if (!queue_full && !redirect) begin
                q.push_back(e);
                next_rob++;
                enq_total++;
            end
        end
        exec_ready = (take_bits(2) != 0);
        operands.rs1_data = (take_bits(2) == 0) ? '0 : xlen_t'(take_bits(64));
        operands.rs2_data = xlen_t'(take_bits(64));
        if (issue_valid) begin
            iss_opnd = operands; // Sampled by the DUT at the coming edge
        end
        commit_rob_idx = (q.size() > 0) ? q[0].rob_idx : next_rob;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dis_valid = 1'b0;
        dis_entry = '0;
        commit_rob_idx = '0;
        fence_commit = 1'b0;
        redirect = 1'b0;
        redirect_rob_idx = '0;
        exec_ready = 1'b0;
        operands = '0;
        store_flush_end = 1'b0;
        inst_flush_end = 1'b0;
        mmu_flush_end = 1'b0;
        next_rob = '0;
        head_issued = 1'b0;
        cdelay = 0;
        iss_opnd = '0;
        fop = CSRRW;
        fence_info = '0;
        exp_req = '0;
        {exp_valid, exp_store, exp_inst, exp_mmu, exp_end, fi_pend, fi_inst} = '0;
        st_cnt = 0;
        in_cnt = 0;
        mm_cnt = 0;
        enq_total = 0;
        cycles = 0;
        done = 1'b0;

        repeat (8) @(negedge clk);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("fence_req.req", fence_req.req, 1'b0);
        check_bit("fence_valid", fence_valid, 1'b0);
        check_bit("store_flush", store_flush, 1'b0);
        check_bit("inst_flush", inst_flush, 1'b0);
        check_bit("mmu_flush", mmu_flush, 1'b0);
        check_bit("fence_end", fence_end, 1'b0);
        check_bit("queue_full", queue_full, 1'b0);
        rst = 1'b0;

        while (!done) begin
            @(negedge clk);
            step();
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                stop_on_error("run did not finish within the cycle limit");
            end
            done = (enq_total >= NUM_INSTR) && (q.size() == 0) && !exp_valid && !exp_end &&
                   (st_cnt == 0) && (in_cnt == 0) && (mm_cnt == 0);
        end
        @(negedge clk);
        step(); // Last look at the outputs once everything has drained
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/csr_iq_pkg.sv
src/csr_queue_ptrs.sv
src/csr_queue_store.sv
src/csr_issue_fsm.sv
src/fence_sequencer.sv
src/csr_issue_top.sv
sim/csr_issue_tb.sv

/* Bender.yml */
package:
  name: csr_issue

sources:
  - include_dirs:
      - src
    files:
      - src/csr_iq_pkg.sv
      - src/csr_queue_ptrs.sv
      - src/csr_queue_store.sv
      - src/csr_issue_fsm.sv
      - src/fence_sequencer.sv
      - src/csr_issue_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/csr_issue_tb.sv
